//--- files.f
+incdir+hdl
hdl/gcode_pkg.sv
hdl/subparser_out_if.sv
hdl/mode_subparser.sv
hdl/linear_subparser.sv
hdl/circular_subparser.sv
hdl/subparser_output_chooser.sv
hdl/gcode_parser_ctrl.sv
hdl/gcode_parser.sv
verification/tb_clock_gen.sv
verification/gcode_parser_sva.sv
verification/gcode_parser_tb.sv

//--- hdl/circular_subparser.sv
`include "gcode_cfg.svh"

module circular_subparser (
	input  logic [`GCODE_CMD_BITS-1:0]        cmd,
	input  logic                              relative,
	input  logic signed [`COORD_BITS-1:0]     x_q,
	input  logic signed [`COORD_BITS-1:0]     y_q,
	input  logic signed [`COORD_BITS-1:0]     i_q,
	input  logic signed [`COORD_BITS-1:0]     j_q,
	input  logic signed [`COORD_BITS-1:0]     pos_x,
	input  logic signed [`COORD_BITS-1:0]     pos_y,
	subparser_out_if.source                   out
);
	import gcode_pkg::*;

	logic signed [`COORD_BITS-1:0] end_x;
	logic signed [`COORD_BITS-1:0] end_y;
	logic signed [`COORD_BITS-1:0] center_x;
	logic signed [`COORD_BITS-1:0] center_y;
	op_st                          op;

	// ======================================================================
	// Arc geometry.
	// ======================================================================

	// End point follows the mode, as for lines.
	always_comb begin
		if (relative) begin
			end_x = pos_x + x_q;
			end_y = pos_y + y_q;
		end else begin
			end_x = x_q;
			end_y = y_q;
		end
	end

	// I and J are offsets from the start point.
	// This holds in both modes.
	assign center_x = pos_x + i_q;
	assign center_y = pos_y + j_q;

	// Direction from the command.
	// G02 clockwise, G03 counter-clockwise.
	always_comb begin
		op = '{opcode: OP_ARC_CCW, default: '0};
		if (cmd == G02)
			op.opcode = OP_ARC_CW;
		op.end_x = end_x;
		op.end_y = end_y;
		op.center_x = center_x;
		op.center_y = center_y;
	end

	// The arc ends on its end point.
	assign out.op = op;
	assign out.new_x = end_x;
	assign out.new_y = end_y;
	assign out.update = 1'b1;

endmodule : circular_subparser

//--- hdl/gcode_cfg.svh
`ifndef GCODE_CFG_SVH
`define GCODE_CFG_SVH

// ==========================================================================
// Widths shared by the parser blocks.
// ==========================================================================

// Width of the G-code command number.
// Wide enough for G90 and G91.
`define GCODE_CMD_BITS 7

// Width of one signed coordinate.
// Sums wrap at this width.
`define COORD_BITS 16

// Coordinates are two's complement.
// Arithmetic on them wraps, with no saturation.

`endif

//--- hdl/gcode_parser.sv
`include "gcode_cfg.svh"

module gcode_parser (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              cmd_valid,
	input  logic [`GCODE_CMD_BITS-1:0]        cmd,
	input  logic signed [`COORD_BITS-1:0]     arg_x,
	input  logic signed [`COORD_BITS-1:0]     arg_y,
	input  logic signed [`COORD_BITS-1:0]     arg_i,
	input  logic signed [`COORD_BITS-1:0]     arg_j,
	output logic                              busy,
	output logic                              op_valid,
	output gcode_pkg::op_st                   op,
	output logic signed [`COORD_BITS-1:0]     pos_x,
	output logic signed [`COORD_BITS-1:0]     pos_y,
	output logic                              relative
);

	// Latched command and arguments.
	logic                          parse;
	logic [`GCODE_CMD_BITS-1:0]    cmd_q;
	logic signed [`COORD_BITS-1:0] x_q;
	logic signed [`COORD_BITS-1:0] y_q;
	logic signed [`COORD_BITS-1:0] i_q;
	logic signed [`COORD_BITS-1:0] j_q;

	// One bundle per subparser, plus the chosen one.
	subparser_out_if lin_if ();
	subparser_out_if circ_if ();
	subparser_out_if mode_if ();
	subparser_out_if chosen_if ();

	gcode_parser_ctrl ctrl_inst (
		.clk(clk), .reset(reset), .cmd_valid(cmd_valid), .cmd(cmd),
		.arg_x(arg_x), .arg_y(arg_y), .arg_i(arg_i), .arg_j(arg_j),
		.chosen(chosen_if.sink), .busy(busy), .op_valid(op_valid), .op(op),
		.pos_x(pos_x), .pos_y(pos_y), .parse(parse), .cmd_q(cmd_q),
		.x_q(x_q), .y_q(y_q), .i_q(i_q), .j_q(j_q)
	);

	// Mode register lives here.
	mode_subparser mode_inst (
		.clk(clk), .reset(reset), .parse(parse), .cmd(cmd_q),
		.relative(relative), .out(mode_if.source)
	);

	linear_subparser lin_inst (
		.cmd(cmd_q), .relative(relative), .x_q(x_q), .y_q(y_q),
		.pos_x(pos_x), .pos_y(pos_y), .out(lin_if.source)
	);

	circular_subparser circ_inst (
		.cmd(cmd_q), .relative(relative), .x_q(x_q), .y_q(y_q),
		.i_q(i_q), .j_q(j_q), .pos_x(pos_x), .pos_y(pos_y),
		.out(circ_if.source)
	);

	subparser_output_chooser chooser_inst (
		.cmd(cmd_q), .lin_in(lin_if.sink), .circ_in(circ_if.sink),
		.mode_in(mode_if.sink), .out(chosen_if.source)
	);

endmodule : gcode_parser

//--- hdl/gcode_parser_ctrl.sv
`include "gcode_cfg.svh"

module gcode_parser_ctrl (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              cmd_valid,
	input  logic [`GCODE_CMD_BITS-1:0]        cmd,
	input  logic signed [`COORD_BITS-1:0]     arg_x,
	input  logic signed [`COORD_BITS-1:0]     arg_y,
	input  logic signed [`COORD_BITS-1:0]     arg_i,
	input  logic signed [`COORD_BITS-1:0]     arg_j,
	subparser_out_if.sink                     chosen,
	output logic                              busy,
	output logic                              op_valid,
	output gcode_pkg::op_st                   op,
	output logic signed [`COORD_BITS-1:0]     pos_x,
	output logic signed [`COORD_BITS-1:0]     pos_y,
	output logic                              parse,
	output logic [`GCODE_CMD_BITS-1:0]        cmd_q,
	output logic signed [`COORD_BITS-1:0]     x_q,
	output logic signed [`COORD_BITS-1:0]     y_q,
	output logic signed [`COORD_BITS-1:0]     i_q,
	output logic signed [`COORD_BITS-1:0]     j_q
);
	import gcode_pkg::*;

	ctrl_state_e state;
	ctrl_state_e next_state;
	logic        accept;

	// ======================================================================
	// Sequencing.
	// ======================================================================

	// New work only from IDLE.
	// Commands during busy are lost.
	assign accept = cmd_valid && (state == IDLE);

	always_comb begin
		next_state = state;
		case (state)
		IDLE:  if (cmd_valid) next_state = PARSE;
		PARSE: next_state = EMIT;
		EMIT:  next_state = IDLE;
		default: next_state = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= IDLE;
		else
			state <= next_state;
	end

	// Busy over PARSE and EMIT.
	assign busy = (state != IDLE);
	// One-cycle strobe to the subparsers.
	assign parse = (state == PARSE);

	// Command capture.
	always_ff @(posedge clk) begin
		if (accept) begin
			cmd_q <= cmd;
			x_q <= arg_x;
			y_q <= arg_y;
			i_q <= arg_i;
			j_q <= arg_j;
		end
	end

	// ======================================================================
	// Result and position.
	// ======================================================================

	// Registered at the end of PARSE.
	// Visible with op_valid in EMIT.
	always_ff @(posedge clk) begin
		if (reset) begin
			op_valid <= 1'b0;
			op <= '{opcode: OP_NONE, default: '0};
			pos_x <= '0;
			pos_y <= '0;
		end else begin
			op_valid <= parse;
			if (parse) begin
				op <= chosen.op;
				// Mode commands leave the position alone.
				if (chosen.update) begin
					pos_x <= chosen.new_x;
					pos_y <= chosen.new_y;
				end
			end
		end
	end

endmodule : gcode_parser_ctrl

//--- hdl/gcode_pkg.sv
`include "gcode_cfg.svh"

package gcode_pkg;

	// ======================================================================
	// Command numbers.
	// ======================================================================

	// Supported G codes.
	// Any other value is an unknown command.
	typedef enum logic [`GCODE_CMD_BITS-1:0] {
		G00 = 7'd0,
		G01 = 7'd1,
		G02 = 7'd2,
		G03 = 7'd3,
		G90 = 7'd90,
		G91 = 7'd91
	} gcode_cmd_e;

	// Motion opcodes handed to the motion side.
	typedef enum logic [2:0] {
		OP_NONE,
		OP_RAPID,
		OP_LINEAR,
		OP_ARC_CW,
		OP_ARC_CCW
	} op_code_e;

	// One parsed operation.
	// Center is zero unless the opcode is an arc.
	typedef struct packed {
		op_code_e                        opcode;
		logic signed [`COORD_BITS-1:0]   end_x;
		logic signed [`COORD_BITS-1:0]   end_y;
		logic signed [`COORD_BITS-1:0]   center_x;
		logic signed [`COORD_BITS-1:0]   center_y;
	} op_st;

	// Controller FSM states.
	typedef enum logic [1:0] {
		IDLE,
		PARSE,
		EMIT
	} ctrl_state_e;

endpackage : gcode_pkg

//--- hdl/linear_subparser.sv
`include "gcode_cfg.svh"

module linear_subparser (
	input  logic [`GCODE_CMD_BITS-1:0]        cmd,
	input  logic                              relative,
	input  logic signed [`COORD_BITS-1:0]     x_q,
	input  logic signed [`COORD_BITS-1:0]     y_q,
	input  logic signed [`COORD_BITS-1:0]     pos_x,
	input  logic signed [`COORD_BITS-1:0]     pos_y,
	subparser_out_if.source                   out
);
	import gcode_pkg::*;

	logic signed [`COORD_BITS-1:0] end_x;
	logic signed [`COORD_BITS-1:0] end_y;
	op_st                          op;

	// ======================================================================
	// End point.
	// ======================================================================

	// Relative mode adds to the current position.
	// Wraps at the coordinate width.
	always_comb begin
		if (relative) begin
			end_x = pos_x + x_q;
			end_y = pos_y + y_q;
		end else begin
			end_x = x_q;
			end_y = y_q;
		end
	end

	// ======================================================================
	// Operation.
	// ======================================================================

	// G00 is rapid, G01 is feed.
	// The chooser only routes those two here.
	always_comb begin
		op = '{opcode: OP_LINEAR, default: '0};
		if (cmd == G00)
			op.opcode = OP_RAPID;
		op.end_x = end_x;
		op.end_y = end_y;
	end

	// Line moves always land on their end point.
	assign out.op = op;
	assign out.new_x = end_x;
	assign out.new_y = end_y;
	assign out.update = 1'b1;

endmodule : linear_subparser

//--- hdl/mode_subparser.sv
`include "gcode_cfg.svh"

module mode_subparser (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       parse,
	input  logic [`GCODE_CMD_BITS-1:0] cmd,
	output logic                       relative,
	subparser_out_if.source            out
);
	import gcode_pkg::*;

	// Absolute/relative mode register.
	// Written only on the parse strobe.
	always_ff @(posedge clk) begin
		if (reset) begin
			relative <= 1'b0;
		end else if (parse) begin
			case (cmd)
			G90: relative <= 1'b0;
			G91: relative <= 1'b1;
			// Unknown codes keep the current mode.
			default: relative <= relative;
			endcase
		end
	end

	// No motion for mode and unknown commands.
	// Position stays put.
	assign out.op = '{opcode: OP_NONE, default: '0};
	assign out.new_x = '0;
	assign out.new_y = '0;
	assign out.update = 1'b0;

endmodule : mode_subparser

//--- hdl/subparser_out_if.sv
`include "gcode_cfg.svh"

interface subparser_out_if;
	import gcode_pkg::*;

	// Operation from one subparser.
	op_st op;

	// Position after the command.
	logic signed [`COORD_BITS-1:0] new_x;
	logic signed [`COORD_BITS-1:0] new_y;

	// Set when the position must be written.
	logic update;

	// Subparser side.
	modport source (output op, new_x, new_y, update);

	// Chooser and controller side.
	modport sink (input op, new_x, new_y, update);

endinterface : subparser_out_if

//--- hdl/subparser_output_chooser.sv
`include "gcode_cfg.svh"

module subparser_output_chooser (
	input  logic [`GCODE_CMD_BITS-1:0] cmd,
	subparser_out_if.sink              lin_in,
	subparser_out_if.sink              circ_in,
	subparser_out_if.sink              mode_in,
	subparser_out_if.source            out
);
	import gcode_pkg::*;

	// Route one subparser by command code.
	// Operation and update fields move together.
	always_comb begin
		case (cmd)
		G00, G01: begin
			out.op = lin_in.op;
			out.new_x = lin_in.new_x;
			out.new_y = lin_in.new_y;
			out.update = lin_in.update;
		end
		G02, G03: begin
			out.op = circ_in.op;
			out.new_x = circ_in.new_x;
			out.new_y = circ_in.new_y;
			out.update = circ_in.update;
		end
		// G90, G91 and unknown codes.
		default: begin
			out.op = mode_in.op;
			out.new_x = mode_in.new_x;
			out.new_y = mode_in.new_y;
			out.update = mode_in.update;
		end
		endcase
	end

endmodule : subparser_output_chooser

//--- verification/gcode_parser_sva.sv
`include "gcode_cfg.svh"

module gcode_parser_sva (
	input logic                          clk,
	input logic                          reset,
	input logic                          cmd_valid,
	input logic [`GCODE_CMD_BITS-1:0]    cmd,
	input logic signed [`COORD_BITS-1:0] arg_x,
	input logic signed [`COORD_BITS-1:0] arg_y,
	input logic signed [`COORD_BITS-1:0] arg_i,
	input logic signed [`COORD_BITS-1:0] arg_j,
	input logic                          busy,
	input logic                          op_valid,
	input gcode_pkg::op_st               op,
	input logic signed [`COORD_BITS-1:0] pos_x,
	input logic signed [`COORD_BITS-1:0] pos_y,
	input logic                          relative
);
	import gcode_pkg::*;

	int fail_count = 0;

	logic                          accepted;
	logic [`GCODE_CMD_BITS-1:0]    held_cmd;
	logic signed [`COORD_BITS-1:0] held_x;
	logic signed [`COORD_BITS-1:0] held_y;
	logic signed [`COORD_BITS-1:0] held_i;
	logic signed [`COORD_BITS-1:0] held_j;
	logic signed [`COORD_BITS-1:0] held_px;
	logic signed [`COORD_BITS-1:0] held_py;
	logic                          held_rel;
	op_code_e                      exp_op;
	logic                          motion;
	logic                          arc;
	logic signed [`COORD_BITS-1:0] exp_ex;
	logic signed [`COORD_BITS-1:0] exp_ey;
	logic signed [`COORD_BITS-1:0] exp_cx;
	logic signed [`COORD_BITS-1:0] exp_cy;
	logic signed [`COORD_BITS-1:0] exp_px;
	logic signed [`COORD_BITS-1:0] exp_py;
	logic                          exp_rel;

	// ======================================================================
	// Reference model.
	// ======================================================================

	// Accepted only while idle.
	assign accepted = cmd_valid && !busy;

	// Command plus position and mode from before it.
	always_ff @(posedge clk) begin
		if (accepted) begin
			held_cmd <= cmd;
			held_x <= arg_x;
			held_y <= arg_y;
			held_i <= arg_i;
			held_j <= arg_j;
			held_px <= pos_x;
			held_py <= pos_y;
			held_rel <= relative;
		end
	end

	// Opcode per command number.
	always_comb begin
		case (held_cmd)
		G00: exp_op = OP_RAPID;
		G01: exp_op = OP_LINEAR;
		G02: exp_op = OP_ARC_CW;
		G03: exp_op = OP_ARC_CCW;
		default: exp_op = OP_NONE;
		endcase
	end

	assign motion = (exp_op != OP_NONE);
	assign arc = (exp_op == OP_ARC_CW) || (exp_op == OP_ARC_CCW);

	// End point by mode, zero for no motion.
	assign exp_ex = !motion ? '0 : (held_rel ? held_px + held_x : held_x);
	assign exp_ey = !motion ? '0 : (held_rel ? held_py + held_y : held_y);
	// Center is an offset from the start, in both modes.
	assign exp_cx = arc ? held_px + held_i : '0;
	assign exp_cy = arc ? held_py + held_j : '0;
	assign exp_px = motion ? exp_ex : held_px;
	assign exp_py = motion ? exp_ey : held_py;
	assign exp_rel = (held_cmd == G90) ? 1'b0 : ((held_cmd == G91) ? 1'b1 : held_rel);

	// ======================================================================
	// Checks.
	// ======================================================================

	property pair_match(got_a, got_b, exp_a, exp_b);
		@(posedge clk) disable iff (reset) op_valid |-> (got_a == exp_a) && (got_b == exp_b);
	endproperty

	// Cleared state right after reset.
	a_reset_state: assert property (@(posedge clk) !reset && $past(reset) |->
		!busy && !op_valid && pos_x == '0 && pos_y == '0 && !relative && op.opcode == OP_NONE)
	else begin
		$error("state after reset is not cleared");
		fail_count++;
	end

	// One op_valid two cycles after each accepted command.
	a_op_timing: assert property (@(posedge clk) disable iff (reset)
		accepted |-> ##2 op_valid)
	else begin
		$error("no op_valid two cycles after an accepted command");
		fail_count++;
	end

	// Nothing else, so dropped commands stay silent.
	a_no_extra: assert property (@(posedge clk) disable iff (reset)
		op_valid |-> $past(accepted, 2))
	else begin
		$error("op_valid without an accepted command two cycles before");
		fail_count++;
	end

	a_busy: assert property (@(posedge clk) disable iff (reset)
		accepted |=> busy ##1 busy ##1 !busy)
	else begin
		$error("busy not high for exactly the two cycles after acceptance");
		fail_count++;
	end

	// Result holds between strobes.
	a_op_hold: assert property (@(posedge clk) disable iff (reset)
		!op_valid |-> $stable(op))
	else begin
		$error("op changed while op_valid was low");
		fail_count++;
	end

	a_opcode: assert property (@(posedge clk) disable iff (reset)
		op_valid |-> op.opcode == exp_op)
	else begin
		$error("Fail t=%0t op.opcode got %0d expected %0d", $time,
			$sampled(op.opcode), $sampled(exp_op));
		fail_count++;
	end

	a_end: assert property (pair_match(op.end_x, op.end_y, exp_ex, exp_ey))
	else begin
		$error("Fail t=%0t op.end_x,op.end_y got %0d,%0d expected %0d,%0d", $time,
			$sampled(op.end_x), $sampled(op.end_y), $sampled(exp_ex), $sampled(exp_ey));
		fail_count++;
	end

	a_center: assert property (pair_match(op.center_x, op.center_y, exp_cx, exp_cy))
	else begin
		$error("Fail t=%0t op.center_x,op.center_y got %0d,%0d expected %0d,%0d", $time,
			$sampled(op.center_x), $sampled(op.center_y), $sampled(exp_cx), $sampled(exp_cy));
		fail_count++;
	end

	a_pos: assert property (pair_match(pos_x, pos_y, exp_px, exp_py))
	else begin
		$error("Fail t=%0t pos_x,pos_y got %0d,%0d expected %0d,%0d", $time,
			$sampled(pos_x), $sampled(pos_y), $sampled(exp_px), $sampled(exp_py));
		fail_count++;
	end

	a_mode: assert property (@(posedge clk) disable iff (reset)
		op_valid |-> relative == exp_rel)
	else begin
		$error("Fail t=%0t relative got %0b expected %0b", $time,
			$sampled(relative), $sampled(exp_rel));
		fail_count++;
	end

endmodule : gcode_parser_sva

bind gcode_parser gcode_parser_sva sva_inst (.*);

//--- verification/gcode_parser_tb.sv
`include "gcode_cfg.svh"

module gcode_parser_tb;
	import gcode_pkg::*;

	// ======================================================================
	// Run length.
	// ======================================================================

	// 22 commands, at most 6 cycles each, after 10 reset cycles.
	localparam int RESET_CYCLES = 10;
	localparam int NUM_CMDS = 22;
	localparam int CMD_CYCLES = 6;
	localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + NUM_CMDS * CMD_CYCLES);

	logic                          clk;
	logic                          reset;
	logic                          cmd_valid;
	logic [`GCODE_CMD_BITS-1:0]    cmd;
	logic signed [`COORD_BITS-1:0] arg_x;
	logic signed [`COORD_BITS-1:0] arg_y;
	logic signed [`COORD_BITS-1:0] arg_i;
	logic signed [`COORD_BITS-1:0] arg_j;
	logic                          busy;
	logic                          op_valid;
	op_st                          op;
	logic signed [`COORD_BITS-1:0] pos_x;
	logic signed [`COORD_BITS-1:0] pos_y;
	logic                          relative;
	logic [31:0]                   lfsr = 32'h5cb2;
	int                            cycles = 0;
	int                            tests = 0;

	tb_clock_gen clock_inst (.clk(clk));

	gcode_parser gcode_parser_inst (.*);

	// Galois form, taps for x^32+x^22+x^2+x+1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One step per bit taken.
	task automatic random_coord(output logic [`COORD_BITS-1:0] v);
		v = '0;
		for (int k = 0; k < `COORD_BITS; k++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[`COORD_BITS-2:0], lfsr[0]};
		end
	endtask

	// Drives one command with random arguments.
	task automatic drive_cmd(input logic [`GCODE_CMD_BITS-1:0] c);
		logic [`COORD_BITS-1:0] v;
		@(posedge clk);
		cmd_valid <= 1'b1;
		cmd <= c;
		random_coord(v);
		arg_x <= v;
		random_coord(v);
		arg_y <= v;
		random_coord(v);
		arg_i <= v;
		random_coord(v);
		arg_j <= v;
	endtask

	// Waits for the result, then one more cycle so the checks have run.
	task automatic wait_result();
		do @(negedge clk); while (op_valid !== 1'b1);
		@(negedge clk);
	endtask

	task automatic issue_cmd(input logic [`GCODE_CMD_BITS-1:0] c);
		drive_cmd(c);
		@(posedge clk);
		cmd_valid <= 1'b0;
		wait_result();
	endtask

	// Second command held on while the first is in flight.
	task automatic issue_during_busy();
		drive_cmd(G01);
		@(posedge clk);
		cmd <= G00;
		arg_x <= 16'h7fff;
		@(posedge clk);
		cmd_valid <= 1'b0;
		wait_result();
	endtask

	task automatic finish_test(input string name);
		tests++;
		$display("%s finished, assertion failures so far %0d", name,
			gcode_parser_inst.sva_inst.fail_count);
	endtask

	// Hang guard.
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout, tests did not end within %0d cycles", TIMEOUT_CYCLES);
			$display("test failed");
			$finish;
		end
	end

	// ======================================================================
	// Test sequence.
	// ======================================================================

	initial begin
		reset = 1'b1;
		cmd_valid = 1'b0;
		cmd = '0;
		arg_x = '0;
		arg_y = '0;
		arg_i = '0;
		arg_j = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;

		issue_cmd(G01);
		issue_during_busy();
		finish_test("reset_timing");

		issue_cmd(G90);
		issue_cmd(G00);
		issue_cmd(G01);
		issue_cmd(G00);
		issue_cmd(G01);
		finish_test("abs_linear");

		// Random sums wrap often.
		issue_cmd(G91);
		repeat (4) issue_cmd(G01);
		finish_test("rel_linear");

		// Relative arcs first, then absolute.
		issue_cmd(G02);
		issue_cmd(G03);
		issue_cmd(G90);
		issue_cmd(G02);
		issue_cmd(G03);
		finish_test("arcs");

		issue_cmd(G91);
		issue_cmd(7'd17);
		issue_cmd(G90);
		issue_cmd(7'd127);
		issue_cmd(G01);
		finish_test("mode_unknown");

		$display("tests run %0d, assertion failures %0d", tests,
			gcode_parser_inst.sva_inst.fail_count);
		if (gcode_parser_inst.sva_inst.fail_count == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule : gcode_parser_tb

//--- verification/tb_clock_gen.sv
module tb_clock_gen (
	output logic clk
);

	// Half of the 100 unit period.
	localparam int HALF_PERIOD = 50;

	// Free running, starts low.
	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

endmodule : tb_clock_gen
